// ==== telemetry_tests.txt ====
# C status ctx en count: status and ctx in hex, status steps by one per cycle
# B button press, U byte (hex), W cycles, E words in the next dump, O overflow_o value
B E 0                 # Empty FIFO, short dump and no characters
C 00010 abc 1 1       # First capture
C 00010 def 1 1       # Context alone changes, no capture
C 00020 123 0 1       # Disabled sample
C 00030 456 1 3       # Three captures
C 00032 789 1 1       # Unchanged status
C fffff 0f0 1 2       # Wraps to 00000, six words stored
O 0
U 62 W 1000           # Not the trigger byte
B E 4                 # First chunk of four
U 61 E 2              # Serial trigger, ends on last
B E 0
C 00100 a5a 1 17      # One more than the FIFO holds
O 1
B W 200 B U 61 E 4    # Requests while busy are dropped
B E 4 B E 4 B E 4
B E 0 O 1             # Overflow stays set

// ==== flist.f ====
telemetry_pkg.sv
uart_pkg.sv
stream_if.sv
change_logger.sv
hex_dumper.sv
uart_link.sv
telemetry_core.sv
telemetry_core_asserts.sv
tb_telemetry_core.sv

// ==== tb_telemetry_core.sv ====
`timescale 1ns/1ns

module tb_telemetry_core;

  logic                                clock = 1'b0;
  logic                                rst_n_i;
  logic                                enable_i;
  logic [telemetry_pkg::SIG_WIDTH-1:0] change_i;
  logic [telemetry_pkg::CTX_WIDTH-1:0] ignore_i;
  logic                                send_n_i;
  logic                                uart_rx_i;
  logic                                uart_tx_o;
  logic                                dumping_o;
  logic                                overflow_o;

  logic [31:0] ref_q [$];  // Words the logger should hold with the oldest first
  logic [7:0]  rx_q [$];   // Characters seen on uart_tx_o
  string       cmd_q [$];
  logic [31:0] arg_q [$];  // Four slots per command

  logic [telemetry_pkg::SIG_WIDTH-1:0] prev_status = '0;
  logic [31:0] rnd = 32'h4909_ca02;
  logic        dumping_prev = 1'b0;
  int          dump_starts = 0;
  int          chars_at_start = 0;
  int          limit_cycles = 0;

  telemetry_core dut_i (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .enable_i   (enable_i),
    .change_i   (change_i),
    .ignore_i   (ignore_i),
    .send_n_i   (send_n_i),
    .uart_rx_i  (uart_rx_i),
    .uart_tx_o  (uart_tx_o),
    .dumping_o  (dumping_o),
    .overflow_o (overflow_o)
  );

  bind telemetry_core telemetry_core_asserts u_asserts (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .word_valid_i (word_s.valid),
    .word_ready_i (word_s.ready),
    .word_data_i  (word_s.data),
    .tx_valid_i   (tx_s.valid),
    .tx_ready_i   (tx_s.ready),
    .tx_data_i    (tx_s.data),
    .tx_idle_i    (u_uart.tx_state_q == uart_pkg::IDLE),
    .uart_tx_i    (uart_tx_o),
    .overflow_i   (overflow_o)
  );

  always #20 clock = ~clock;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [7:0] ascii_hex(input logic [3:0] nibble);
    string digits;
    digits = "0123456789ABCDEF";
    return digits[nibble];
  endfunction

  task automatic abort_run();
    $display(">>> FAIL");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[FAIL] t=%0t %s: got 0x%0h, expected 0x%0h", $time, name, actual, expected);
      abort_run();
    end
  endtask

  task automatic idle_cycles();
    rnd = lcg_next(rnd);
    repeat (rnd[17:16]) @(negedge clock);  // 0 to 3 cycles
  endtask

  // Status steps by one per cycle while the context holds
  task automatic apply_status(input logic [31:0] status, input logic [31:0] ctx,
                              input logic en, input int count);
    logic [telemetry_pkg::SIG_WIDTH-1:0] value;
    for (int i = 0; i < count; i++) begin
      value    = telemetry_pkg::SIG_WIDTH'(status + i);
      change_i = value;
      ignore_i = ctx[telemetry_pkg::CTX_WIDTH-1:0];
      enable_i = en;
      if (en && value != prev_status && ref_q.size() < telemetry_pkg::FIFO_DEPTH) begin
        ref_q.push_back({ctx[telemetry_pkg::CTX_WIDTH-1:0], value});
      end
      prev_status = value;  // Reloaded every cycle whether enabled or not
      @(negedge clock);
    end
    enable_i = 1'b0;
  endtask

  task automatic press_button();
    send_n_i = 1'b0;
    repeat (4) @(negedge clock);
    send_n_i = 1'b1;
  endtask

  task automatic send_serial(input logic [7:0] data);
    uart_rx_i = 1'b0;  // Start bit
    repeat (uart_pkg::CLKS_PER_BIT) @(negedge clock);
    for (int i = 0; i < 8; i++) begin
      uart_rx_i = data[i];
      repeat (uart_pkg::CLKS_PER_BIT) @(negedge clock);
    end
    uart_rx_i = 1'b1;
    repeat (uart_pkg::CLKS_PER_BIT) @(negedge clock);
  endtask

  task automatic expect_dump(input int words);
    logic [31:0] word;
    if (words > 0) begin
      while (dump_starts == 0) @(negedge clock);
      while (dumping_o) @(negedge clock);
      while (rx_q.size() < words * (telemetry_pkg::HEX_DIGITS + 2)) @(negedge clock);
    end
    // Room for one more frame that must not come
    repeat (12 * uart_pkg::CLKS_PER_BIT) @(negedge clock);
    check_value("dump starts", dump_starts, 1);
    check_value("chars before dumping_o", chars_at_start, 0);
    check_value("dumping_o", dumping_o, 1'b0);
    check_value("dump length", rx_q.size(), words * (telemetry_pkg::HEX_DIGITS + 2));
    for (int w = 0; w < words; w++) begin
      word = ref_q.pop_front();
      for (int d = 0; d < 8; d++) begin
        check_value("hex char", rx_q.pop_front(), ascii_hex(word[31 - 4 * d -: 4]));
      end
      check_value("CR char", rx_q.pop_front(), 8'h0d);
      check_value("LF char", rx_q.pop_front(), 8'h0a);
    end
    dump_starts = 0;
  endtask

  // Serial receiver model sampling uart_tx_o near mid-bit
  always begin : serial_rx
    logic [7:0] rx_byte;
    @(negedge clock);
    if (rst_n_i === 1'b1 && uart_tx_o === 1'b0) begin
      repeat (uart_pkg::CLKS_PER_BIT / 2 - 1) @(negedge clock);
      check_value("uart_tx_o start bit", uart_tx_o, 1'b0);
      for (int i = 0; i < 8; i++) begin
        repeat (uart_pkg::CLKS_PER_BIT) @(negedge clock);
        rx_byte[i] = uart_tx_o;
      end
      repeat (uart_pkg::CLKS_PER_BIT) @(negedge clock);
      check_value("uart_tx_o stop bit", uart_tx_o, 1'b1);
      rx_q.push_back(rx_byte);
    end
  end

  always @(negedge clock) begin
    if (dumping_o === 1'b1 && !dumping_prev) begin
      dump_starts++;
      chars_at_start = rx_q.size();
    end
    dumping_prev = (dumping_o === 1'b1);
    if (dut_i.u_asserts.error_count != 0) begin
      $display("A protocol assertion failed at t=%0t", $time);
      abort_run();
    end
  end

  initial begin : watchdog
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clock);
    $display("Timeout: the tests did not finish within %0d cycles", limit_cycles);
    abort_run();
  end

  initial begin
    string       tok;
    string       line;
    int          fd;
    int          n;
    int          total;
    logic        quiet_wait;
    logic [31:0] v [4];

    rst_n_i    = 1'b0;
    enable_i   = 1'b0;
    change_i   = '0;
    ignore_i   = '0;
    send_n_i   = 1'b1;
    uart_rx_i  = 1'b1;
    total      = 0;
    quiet_wait = 1'b0;

    fd = $fopen("telemetry_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open telemetry_tests.txt");
      abort_run();
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      v = '{default: '0};
      if (tok[0] == "#") begin
        n = $fgets(line, fd);  // Rest of the line is a comment
      end else begin
        case (tok)
          "B":           n = 0;
          "C":           n = $fscanf(fd, "%h %h %d %d", v[0], v[1], v[2], v[3]);
          "U":           n = $fscanf(fd, "%h", v[0]);
          "W", "E", "O": n = $fscanf(fd, "%d", v[0]);
          default: begin
            $display("Unknown command %s in telemetry_tests.txt", tok);
            abort_run();
          end
        endcase
        cmd_q.push_back(tok);
        foreach (v[i]) arg_q.push_back(v[i]);
        total += 2000 + ((tok == "E") ? 100 * v[0] : 0);
      end
    end
    $fclose(fd);
    limit_cycles = total;

    repeat (3) @(negedge clock);
    rst_n_i = 1'b1;
    check_value("uart_tx_o", uart_tx_o, 1'b1);
    check_value("dumping_o", dumping_o, 1'b0);
    check_value("overflow_o", overflow_o, 1'b0);

    while (cmd_q.size() > 0) begin
      tok = cmd_q.pop_front();
      foreach (v[i]) v[i] = arg_q.pop_front();
      case (tok)
        "C":     apply_status(v[0], v[1], v[2][0], v[3]);
        "B":     press_button();
        "U":     send_serial(v[0][7:0]);
        "W": begin
          repeat (v[0]) @(negedge clock);
          if (quiet_wait) begin  // A byte other than "a" starts nothing
            check_value("dump starts", dump_starts, 0);
            check_value("chars on uart_tx_o", rx_q.size(), 0);
          end
        end
        "E":     expect_dump(v[0]);
        default: check_value("overflow_o", overflow_o, v[0]);
      endcase
      quiet_wait = (tok == "U") && (v[0][7:0] != "a");
      idle_cycles();
    end

    if (dut_i.u_asserts.error_count == 0) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("A protocol assertion failed during the run");
      abort_run();
    end
  end

endmodule

// ==== telemetry_core_asserts.sv ====
`timescale 1ns/1ns

module telemetry_core_asserts (
  input logic                                 clock,
  input logic                                 rst_n_i,
  input logic                                 word_valid_i,
  input logic                                 word_ready_i,
  input logic [telemetry_pkg::WORD_WIDTH-1:0] word_data_i,
  input logic                                 tx_valid_i,
  input logic                                 tx_ready_i,
  input logic [uart_pkg::DATA_BITS-1:0]       tx_data_i,
  input logic                                 tx_idle_i,   // Transmitter FSM in IDLE
  input logic                                 uart_tx_i,
  input logic                                 overflow_i
);

  int unsigned error_count = 0;

  // A stalled beat keeps valid and data
  word_stable_a : assert property (@(posedge clock) disable iff (!rst_n_i)
    word_valid_i && !word_ready_i |=> word_valid_i && $stable(word_data_i))
    else begin
      $error("word_s dropped valid or changed data while stalled");
      error_count++;
    end

  tx_stable_a : assert property (@(posedge clock) disable iff (!rst_n_i)
    tx_valid_i && !tx_ready_i |=> tx_valid_i && $stable(tx_data_i))
    else begin
      $error("tx_s dropped valid or changed data while stalled");
      error_count++;
    end

  line_idle_a : assert property (@(posedge clock) disable iff (!rst_n_i)
    tx_idle_i |-> uart_tx_i)
    else begin
      $error("uart_tx_o low while the transmitter is idle");
      error_count++;
    end

  overflow_sticky_a : assert property (@(posedge clock) disable iff (!rst_n_i)
    !$fell(overflow_i))
    else begin
      $error("overflow_o fell outside reset");
      error_count++;
    end

endmodule

// ==== telemetry_core.sv ====
`timescale 1ns/1ns

module telemetry_core (
  input  logic                                clock,
  input  logic                                rst_n_i,
  input  logic                                enable_i,
  input  logic [telemetry_pkg::SIG_WIDTH-1:0] change_i,
  input  logic [telemetry_pkg::CTX_WIDTH-1:0] ignore_i,
  input  logic                                send_n_i,
  input  logic                                uart_rx_i,
  output logic                                uart_tx_o,
  output logic                                dumping_o,
  output logic                                overflow_o
);

  stream_if #(.WIDTH(telemetry_pkg::WORD_WIDTH)) word_s ();  // Captured words
  stream_if #(.WIDTH(uart_pkg::DATA_BITS))       tx_s ();    // ASCII out
  stream_if #(.WIDTH(uart_pkg::DATA_BITS))       rx_s ();    // Serial commands in

  change_logger u_logger (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .enable_i   (enable_i),
    .change_i   (change_i),
    .ignore_i   (ignore_i),
    .word_s     (word_s),
    .overflow_o (overflow_o)
  );

  hex_dumper u_dumper (
    .clock     (clock),
    .rst_n_i   (rst_n_i),
    .send_n_i  (send_n_i),
    .word_s    (word_s),
    .rx_s      (rx_s),
    .tx_s      (tx_s),
    .dumping_o (dumping_o)
  );

  uart_link u_uart (
    .clock     (clock),
    .rst_n_i   (rst_n_i),
    .tx_s      (tx_s),
    .rx_s      (rx_s),
    .uart_rx_i (uart_rx_i),
    .uart_tx_o (uart_tx_o)
  );

endmodule

// ==== uart_link.sv ====
`timescale 1ns/1ns

module uart_link (
  input  logic     clock,
  input  logic     rst_n_i,
  stream_if.sink   tx_s,
  stream_if.source rx_s,
  input  logic     uart_rx_i,
  output logic     uart_tx_o
);

  uart_pkg::uart_state_e tx_state_q;
  uart_pkg::uart_state_e rx_state_q;

  logic [uart_pkg::CNT_WIDTH-1:0] tx_cnt_q, rx_cnt_q;   // Clocks within a bit
  logic [uart_pkg::IDX_WIDTH-1:0] tx_idx_q, rx_idx_q;   // Data bit index
  logic [uart_pkg::DATA_BITS-1:0] tx_shift_q, rx_shift_q, rx_data_q;

  logic rx_meta_q;
  logic rx_sync_q;
  logic rx_valid_q;
  logic tx_tick_w;
  logic rx_tick_w;

  assign tx_tick_w  = (tx_cnt_q == uart_pkg::BIT_LAST);
  assign rx_tick_w  = (rx_cnt_q == uart_pkg::BIT_LAST);
  assign tx_s.ready = (tx_state_q == uart_pkg::IDLE);  // Low for the whole frame

  assign rx_s.valid = rx_valid_q;
  assign rx_s.data  = rx_data_q;
  assign rx_s.last  = 1'b1;  // Every byte stands alone

  always_ff @(posedge clock) begin
    if (tx_s.valid && tx_s.ready) begin
      tx_shift_q <= tx_s.data;
    end else if (tx_state_q == uart_pkg::DATA && tx_tick_w) begin
      tx_shift_q <= tx_shift_q >> 1;
    end
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      tx_state_q <= uart_pkg::IDLE;
      tx_cnt_q   <= '0;
      tx_idx_q   <= '0;
      uart_tx_o  <= 1'b1;
    end else begin
      tx_cnt_q <= tx_tick_w ? '0 : tx_cnt_q + 1'b1;
      case (tx_state_q)
        uart_pkg::IDLE: begin
          tx_cnt_q  <= '0;
          uart_tx_o <= ~tx_s.valid;  // Start bit goes out with the transfer
          if (tx_s.valid) tx_state_q <= uart_pkg::START;
        end
        uart_pkg::START: if (tx_tick_w) begin
          tx_idx_q   <= '0;
          uart_tx_o  <= tx_shift_q[0];
          tx_state_q <= uart_pkg::DATA;
        end
        uart_pkg::DATA: if (tx_tick_w) begin
          tx_idx_q <= tx_idx_q + 1'b1;
          if (tx_idx_q == uart_pkg::IDX_LAST) begin
            uart_tx_o  <= 1'b1;  // Stop bit
            tx_state_q <= uart_pkg::STOP;
          end else begin
            uart_tx_o <= tx_shift_q[1];
          end
        end
        default: if (tx_tick_w) tx_state_q <= uart_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (rx_state_q == uart_pkg::DATA && rx_tick_w) begin
      rx_shift_q <= {rx_sync_q, rx_shift_q[uart_pkg::DATA_BITS-1:1]};
    end
    if (rx_state_q == uart_pkg::STOP && rx_tick_w && rx_sync_q) begin
      rx_data_q <= rx_shift_q;
    end
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rx_meta_q  <= 1'b1;
      rx_sync_q  <= 1'b1;
      rx_state_q <= uart_pkg::IDLE;
      rx_cnt_q   <= '0;
      rx_idx_q   <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_meta_q <= uart_rx_i;
      rx_sync_q <= rx_meta_q;
      rx_cnt_q  <= rx_tick_w ? '0 : rx_cnt_q + 1'b1;
      if (rx_s.ready) rx_valid_q <= 1'b0;
      case (rx_state_q)
        uart_pkg::IDLE: begin
          rx_cnt_q <= '0;
          if (!rx_sync_q) rx_state_q <= uart_pkg::START;
        end
        // Re-check the start bit at mid-bit
        uart_pkg::START: if (rx_cnt_q == uart_pkg::HALF_LAST) begin
          rx_cnt_q   <= '0;
          rx_idx_q   <= '0;
          rx_state_q <= rx_sync_q ? uart_pkg::IDLE : uart_pkg::DATA;
        end
        uart_pkg::DATA: if (rx_tick_w) begin
          rx_idx_q <= rx_idx_q + 1'b1;
          if (rx_idx_q == uart_pkg::IDX_LAST) rx_state_q <= uart_pkg::STOP;
        end
        default: if (rx_tick_w) begin
          if (rx_sync_q) rx_valid_q <= 1'b1;  // Good stop bit only
          rx_state_q <= uart_pkg::IDLE;
        end
      endcase
    end
  end

endmodule

// ==== hex_dumper.sv ====
`timescale 1ns/1ns

module hex_dumper (
  input  logic     clock,
  input  logic     rst_n_i,
  input  logic     send_n_i,  // Dump button, active low
  stream_if.sink   word_s,
  stream_if.sink   rx_s,
  stream_if.source tx_s,
  output logic     dumping_o
);

  telemetry_pkg::dump_state_e state_q;

  logic send_meta_q;
  logic send_sync_q;
  logic send_prev_q;
  logic start_q;
  logic last_q;  // Current word emptied the FIFO
  logic trigger_w;
  logic tx_done_w;
  logic end_w;

  logic [telemetry_pkg::WORD_WIDTH-1:0]  word_q;
  logic [telemetry_pkg::DIGIT_WIDTH-1:0] digit_q;
  logic [telemetry_pkg::PKT_WIDTH-1:0]   words_q;

  function automatic logic [7:0] to_hex(input logic [3:0] nibble);
    if (nibble < 4'd10) begin
      return 8'h30 + {4'h0, nibble};
    end
    return 8'h37 + {4'h0, nibble};  // Upper-case A to F
  endfunction

  // Button falling edge or an "a" from the serial line
  assign trigger_w = (send_prev_q & ~send_sync_q) |
                     (rx_s.valid & (rx_s.data == uart_pkg::TRIGGER_CHAR));
  assign rx_s.ready   = 1'b1;
  assign word_s.ready = (state_q == telemetry_pkg::FETCH);

  assign tx_s.valid = (state_q == telemetry_pkg::EMIT_HEX) |
                      (state_q == telemetry_pkg::EMIT_CR) |
                      (state_q == telemetry_pkg::EMIT_LF);
  assign tx_done_w  = tx_s.valid & tx_s.ready;
  assign end_w      = last_q | (words_q == telemetry_pkg::PKT_LAST);
  assign tx_s.last  = (state_q == telemetry_pkg::EMIT_LF) & end_w;
  assign dumping_o  = (state_q != telemetry_pkg::IDLE);

  always_comb begin
    case (state_q)
      telemetry_pkg::EMIT_CR: tx_s.data = telemetry_pkg::ASCII_CR;
      telemetry_pkg::EMIT_LF: tx_s.data = telemetry_pkg::ASCII_LF;
      default:                tx_s.data = to_hex(word_q[telemetry_pkg::WORD_WIDTH-1 -: 4]);
    endcase
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      send_meta_q <= 1'b1;
      send_sync_q <= 1'b1;
      send_prev_q <= 1'b1;
    end else begin
      send_meta_q <= send_n_i;
      send_sync_q <= send_meta_q;
      send_prev_q <= send_sync_q;
    end
  end

  // MSB nibble first, shifted out as each digit goes
  always_ff @(posedge clock) begin
    if (word_s.valid && word_s.ready) begin
      word_q <= word_s.data;
    end else if (state_q == telemetry_pkg::EMIT_HEX && tx_done_w) begin
      word_q <= word_q << 4;
    end
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= telemetry_pkg::IDLE;
      start_q <= 1'b0;
      last_q  <= 1'b0;
      digit_q <= '0;
      words_q <= '0;
    end else begin
      start_q <= trigger_w & (state_q == telemetry_pkg::IDLE);  // Ignored while busy
      case (state_q)
        telemetry_pkg::IDLE: if (start_q) begin
          words_q <= '0;
          state_q <= telemetry_pkg::FETCH;
        end
        telemetry_pkg::FETCH: if (word_s.valid) begin
          last_q  <= word_s.last;
          words_q <= words_q + 1'b1;
          digit_q <= '0;
          state_q <= telemetry_pkg::EMIT_HEX;
        end else begin
          state_q <= telemetry_pkg::IDLE;  // Nothing left to send
        end
        telemetry_pkg::EMIT_HEX: if (tx_done_w) begin
          digit_q <= digit_q + 1'b1;
          if (digit_q == telemetry_pkg::DIGIT_LAST) state_q <= telemetry_pkg::EMIT_CR;
        end
        telemetry_pkg::EMIT_CR: if (tx_done_w) state_q <= telemetry_pkg::EMIT_LF;
        telemetry_pkg::EMIT_LF: if (tx_done_w) begin
          state_q <= end_w ? telemetry_pkg::IDLE : telemetry_pkg::FETCH;
        end
        default: state_q <= telemetry_pkg::IDLE;
      endcase
    end
  end

endmodule

// ==== change_logger.sv ====
`timescale 1ns/1ns

module change_logger (
  input  logic                                clock,
  input  logic                                rst_n_i,
  input  logic                                enable_i,
  input  logic [telemetry_pkg::SIG_WIDTH-1:0] change_i,
  input  logic [telemetry_pkg::CTX_WIDTH-1:0] ignore_i,
  stream_if.source                            word_s,
  output logic                                overflow_o
);

  logic [telemetry_pkg::WORD_WIDTH-1:0] mem_q [telemetry_pkg::FIFO_DEPTH];

  logic [telemetry_pkg::SIG_WIDTH-1:0] prev_q;   // Status seen last cycle
  logic [telemetry_pkg::PTR_WIDTH-1:0] wr_ptr_q;
  logic [telemetry_pkg::PTR_WIDTH-1:0] rd_ptr_q;
  logic [telemetry_pkg::LVL_WIDTH-1:0] count_q;

  logic capture_w;
  logic full_w;
  logic push_w;
  logic pop_w;

  // Only the status vector can trigger a capture
  assign capture_w = enable_i & (change_i != prev_q);
  assign full_w    = (count_q == telemetry_pkg::LVL_FULL);
  assign push_w    = capture_w & ~full_w;
  assign pop_w     = word_s.valid & word_s.ready;

  assign word_s.valid = (count_q != '0);
  assign word_s.last  = (count_q == telemetry_pkg::LVL_ONE);  // This word empties the FIFO
  assign word_s.data  = mem_q[rd_ptr_q];

  always_ff @(posedge clock) begin
    if (push_w) begin
      mem_q[wr_ptr_q] <= {ignore_i, change_i};
    end
  end

  always_ff @(posedge clock or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prev_q     <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      overflow_o <= 1'b0;
    end else begin
      prev_q <= change_i;

      if (push_w) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;  // Wraps, depth is a power of two
      end
      if (pop_w) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end

      case ({push_w, pop_w})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase

      // Sticky until reset
      if (capture_w && full_w) begin
        overflow_o <= 1'b1;
      end
    end
  end

endmodule

// ==== stream_if.sv ====
`timescale 1ns/1ns

// Valid/ready stream, transfer on valid and ready at the clock edge
interface stream_if #(
  parameter int WIDTH = 8
);

  logic             valid;
  logic             ready;
  logic             last;   // Final beat of a packet
  logic [WIDTH-1:0] data;

  modport source (
    output valid,
    output last,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  last,
    input  data,
    output ready
  );

endinterface

// ==== uart_pkg.sv ====
package uart_pkg;

  localparam int CLKS_PER_BIT = 8;
  localparam int CNT_WIDTH    = $clog2(CLKS_PER_BIT);
  localparam logic [CNT_WIDTH-1:0] BIT_LAST  = CNT_WIDTH'(CLKS_PER_BIT - 1);
  localparam logic [CNT_WIDTH-1:0] HALF_LAST = CNT_WIDTH'(CLKS_PER_BIT / 2 - 1);

  // 8N1 frame, LSB first
  localparam int DATA_BITS = 8;
  localparam int IDX_WIDTH = $clog2(DATA_BITS);
  localparam logic [IDX_WIDTH-1:0] IDX_LAST = IDX_WIDTH'(DATA_BITS - 1);

  localparam logic [DATA_BITS-1:0] TRIGGER_CHAR = 8'h61;  // ASCII "a"

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_e;

endpackage

// ==== telemetry_pkg.sv ====
package telemetry_pkg;

  // Capture word layout, context on top of the watched status
  localparam int SIG_WIDTH  = 20;
  localparam int CTX_WIDTH  = 12;                     // Never triggers a capture
  localparam int WORD_WIDTH = CTX_WIDTH + SIG_WIDTH;  // 32

  localparam int FIFO_DEPTH = 16;
  localparam int PTR_WIDTH  = $clog2(FIFO_DEPTH);
  localparam int LVL_WIDTH  = PTR_WIDTH + 1;
  localparam logic [LVL_WIDTH-1:0] LVL_FULL = LVL_WIDTH'(FIFO_DEPTH);
  localparam logic [LVL_WIDTH-1:0] LVL_ONE  = LVL_WIDTH'(1);

  // Words per dump
  localparam int PACKET_WORDS = 4;
  localparam int PKT_WIDTH    = $clog2(PACKET_WORDS + 1);
  localparam logic [PKT_WIDTH-1:0] PKT_LAST = PKT_WIDTH'(PACKET_WORDS);

  // Eight hex digits per line, then CR LF
  localparam int HEX_DIGITS  = WORD_WIDTH / 4;
  localparam int DIGIT_WIDTH = $clog2(HEX_DIGITS);
  localparam logic [DIGIT_WIDTH-1:0] DIGIT_LAST = DIGIT_WIDTH'(HEX_DIGITS - 1);
  localparam logic [7:0] ASCII_CR = 8'h0d;
  localparam logic [7:0] ASCII_LF = 8'h0a;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,     // Take one word from the FIFO
    EMIT_HEX,
    EMIT_CR,
    EMIT_LF
  } dump_state_e;

endpackage
